/* source/lstm_shape_pkg.sv */
package lstm_shape_pkg;

	////////////////////////////////////////
	// Network dimensions
	////////////////////////////////////////

	// Dot product length
	localparam int NUM_CELL = 4;
	// Dot products per timestep
	localparam int NUM_INPUT = 3;
	localparam int TIMESTEP = 3;

	// Delta store, one word per cell per timestep
	localparam int D_DEPTH = NUM_CELL * TIMESTEP;
	// Weight store, NUM_INPUT columns by NUM_CELL rows
	localparam int W_DEPTH = NUM_CELL * NUM_INPUT;
	// Wide enough for the larger store
	localparam int ADDR_W = $clog2((D_DEPTH > W_DEPTH) ? D_DEPTH : W_DEPTH);

	// Base of the last timestep in the delta store
	localparam int D_LAST_BASE = (TIMESTEP - 1) * NUM_CELL;

	// Idle cycles after each dot product
	localparam int DELAY = 2;
	// Results per run
	localparam int NUM_DOTS = TIMESTEP * NUM_INPUT;

	typedef logic [ADDR_W-1:0] addr_t;

	// Address generator sequencing
	typedef enum logic [1:0] {AG_IDLE, AG_STREAM, AG_GAP} ag_state_e;

endpackage

/* source/lstm_fixed_pkg.sv */
package lstm_fixed_pkg;

	////////////////////////////////////////
	// Fixed-point formats
	////////////////////////////////////////

	// Q7.8 values
	localparam int DATA_W = 16;
	localparam int FRAC_BITS = 8;
	// Full precision product of two values
	localparam int PROD_W = 2 * DATA_W;
	// Headroom for long dot products
	localparam int ACC_W = 40;

	typedef logic signed [DATA_W-1:0] dat_t;
	typedef logic signed [PROD_W-1:0] prod_t;
	typedef logic signed [ACC_W-1:0] acc_t;

	////////////////////////////////////////
	// Saturation limits
	////////////////////////////////////////

	// Largest positive value
	localparam dat_t DAT_MAX = {1'b0, {(DATA_W-1){1'b1}}};
	// Most negative value
	localparam dat_t DAT_MIN = {1'b1, {(DATA_W-1){1'b0}}};

endpackage

/* source/bp_sram.sv */
`timescale 1ns/1ps

module bp_sram #(
	parameter int DEPTH = 12
) (
	input  logic                  clk,
	input  logic                  i_we,
	input  lstm_shape_pkg::addr_t i_waddr,
	input  lstm_shape_pkg::addr_t i_raddr,
	input  lstm_fixed_pkg::dat_t  i_wdata,
	output lstm_fixed_pkg::dat_t  o_rdata
);
	import lstm_fixed_pkg::*;

	// Storage array
	dat_t mem [DEPTH];

	// Write port, loaded from outside while idle
	always_ff @(posedge clk)
	begin
		if (i_we)
		begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// Read port with one cycle latency
	always_ff @(posedge clk)
	begin
		o_rdata <= mem[i_raddr];
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Loader must not write past the array
	assert property (@(posedge clk) i_we |-> (int'(i_waddr) < DEPTH));

endmodule

/* source/addr_gen_bp_dxdout.sv */
`timescale 1ns/1ps

module addr_gen_bp_dxdout (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  i_start,
	output lstm_shape_pkg::addr_t o_addr_d,
	output lstm_shape_pkg::addr_t o_addr_w,
	output logic                  o_rd_vld,
	output logic                  o_rd_last,
	output logic                  o_busy,
	output logic                  o_done
);
	import lstm_shape_pkg::*;

	ag_state_e state;

	// Element position inside the current dot product
	addr_t cell_cnt;
	// Idle cycles spent after a dot product
	addr_t gap_cnt;
	// Input being processed within the timestep
	addr_t in_idx;
	// Start addresses of the next dot product
	addr_t off_d;
	addr_t off_w;

	// Final dot product is the last input of timestep 0
	logic last_dot;

	assign last_dot = (in_idx == addr_t'(NUM_INPUT - 1)) && (off_d == '0);
	assign o_busy = (state != AG_IDLE);

	////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state     <= AG_IDLE;
			o_addr_d  <= '0;
			o_addr_w  <= '0;
			o_rd_vld  <= 1'b0;
			o_rd_last <= 1'b0;
			o_done    <= 1'b0;
			cell_cnt  <= '0;
			gap_cnt   <= '0;
			in_idx    <= '0;
			off_d     <= '0;
			off_w     <= '0;
		end
		else
		begin
			// Single cycle pulse by default
			o_done <= 1'b0;
			case (state)
				AG_IDLE:
				begin
					// Walk begins at the last timestep, first input
					if (i_start)
					begin
						state     <= AG_STREAM;
						o_addr_d  <= addr_t'(D_LAST_BASE);
						o_addr_w  <= '0;
						o_rd_vld  <= 1'b1;
						o_rd_last <= (NUM_CELL == 1);
						cell_cnt  <= '0;
						in_idx    <= '0;
						off_d     <= addr_t'(D_LAST_BASE);
						off_w     <= '0;
					end
				end
				AG_STREAM:
				begin
					if (cell_cnt == addr_t'(NUM_CELL - 1))
					begin
						// Final element of this dot product is on the bus
						o_rd_vld  <= 1'b0;
						o_rd_last <= 1'b0;
						gap_cnt   <= '0;
						if (last_dot)
						begin
							state  <= AG_IDLE;
							o_done <= 1'b1;
						end
						else
						begin
							state <= AG_GAP;
						end
						// Input wrap moves down one timestep
						if (in_idx == addr_t'(NUM_INPUT - 1))
						begin
							in_idx <= '0;
							off_w  <= '0;
							off_d  <= off_d - addr_t'(NUM_CELL);
						end
						else
						begin
							in_idx <= in_idx + addr_t'(1);
							off_w  <= off_w + addr_t'(1);
						end
					end
					else
					begin
						// Delta is contiguous, weight strides one row
						cell_cnt  <= cell_cnt + addr_t'(1);
						o_addr_d  <= o_addr_d + addr_t'(1);
						o_addr_w  <= o_addr_w + addr_t'(NUM_INPUT);
						o_rd_vld  <= 1'b1;
						o_rd_last <= (cell_cnt == addr_t'(NUM_CELL - 2));
					end
				end
				AG_GAP:
				begin
					if (gap_cnt == addr_t'(DELAY - 1))
					begin
						// Relaunch from the stored offsets
						state     <= AG_STREAM;
						o_addr_d  <= off_d;
						o_addr_w  <= off_w;
						o_rd_vld  <= 1'b1;
						o_rd_last <= (NUM_CELL == 1);
						cell_cnt  <= '0;
					end
					else
					begin
						gap_cnt <= gap_cnt + addr_t'(1);
					end
				end
				default:
				begin
					state <= AG_IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Reads stay inside both stores
	assert property (@(posedge clk) disable iff (rst)
		o_rd_vld |-> (int'(o_addr_d) < D_DEPTH) && (int'(o_addr_w) < W_DEPTH));

	// Last only marks a real element
	assert property (@(posedge clk) disable iff (rst) o_rd_last |-> o_rd_vld);

endmodule

/* source/dot_accum.sv */
`timescale 1ns/1ps

module dot_accum (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 i_vld,
	input  logic                 i_last,
	input  lstm_fixed_pkg::dat_t i_d,
	input  lstm_fixed_pkg::dat_t i_w,
	output lstm_fixed_pkg::dat_t o_dx,
	output logic                 o_dx_vld
);
	import lstm_fixed_pkg::*;

	// Strobes lined up with memory read data
	logic  vld_q;
	logic  last_q;
	// Product stage
	prod_t prod;
	logic  prod_vld;
	logic  prod_last;
	// Sum stage
	acc_t  acc;
	acc_t  sum_next;
	acc_t  sum_shift;
	dat_t  sum_sat;

	////////////////////////////////////////
	// Strobe pipeline
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			vld_q     <= 1'b0;
			last_q    <= 1'b0;
			prod_vld  <= 1'b0;
			prod_last <= 1'b0;
		end
		else
		begin
			vld_q     <= i_vld;
			last_q    <= i_vld & i_last;
			prod_vld  <= vld_q;
			prod_last <= last_q;
		end
	end

	// Full precision product
	always_ff @(posedge clk)
	begin
		if (vld_q)
		begin
			prod <= i_d * i_w;
		end
	end

	////////////////////////////////////////
	// Accumulate, scale, saturate
	////////////////////////////////////////

	always_comb
	begin
		sum_next = acc + acc_t'(prod);
		// Drop fraction bits, rounds toward minus infinity
		sum_shift = sum_next >>> FRAC_BITS;
		if (sum_shift > acc_t'(DAT_MAX))
			sum_sat = DAT_MAX;
		else if (sum_shift < acc_t'(DAT_MIN))
			sum_sat = DAT_MIN;
		else
			sum_sat = dat_t'(sum_shift);
	end

	// Running sum, back to zero once a dot product closes
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			acc      <= '0;
			o_dx_vld <= 1'b0;
		end
		else
		begin
			o_dx_vld <= prod_vld & prod_last;
			if (prod_vld)
			begin
				acc <= prod_last ? '0 : sum_next;
			end
		end
	end

	// Result register
	always_ff @(posedge clk)
	begin
		if (prod_vld && prod_last)
		begin
			o_dx <= sum_sat;
		end
	end

	// Gap between dot products keeps results apart
	assert property (@(posedge clk) disable iff (rst) o_dx_vld |=> !o_dx_vld);

endmodule

/* source/bp_dxdout_top.sv */
`timescale 1ns/1ps

module bp_dxdout_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  i_start,
	// Delta store load port
	input  logic                  i_d_we,
	input  lstm_shape_pkg::addr_t i_d_waddr,
	input  lstm_fixed_pkg::dat_t  i_d_wdata,
	// Weight store load port
	input  logic                  i_w_we,
	input  lstm_shape_pkg::addr_t i_w_waddr,
	input  lstm_fixed_pkg::dat_t  i_w_wdata,
	// Results
	output lstm_fixed_pkg::dat_t  o_dx,
	output logic                  o_dx_vld,
	output logic                  o_busy,
	output logic                  o_done
);
	import lstm_shape_pkg::*;
	import lstm_fixed_pkg::*;

	// Read side of both stores
	addr_t addr_d;
	addr_t addr_w;
	logic  rd_vld;
	logic  rd_last;
	dat_t  d_rdata;
	dat_t  w_rdata;

	////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////

	addr_gen_bp_dxdout ag0 (
		.clk       (clk),
		.rst       (rst),
		.i_start   (i_start),
		.o_addr_d  (addr_d),
		.o_addr_w  (addr_w),
		.o_rd_vld  (rd_vld),
		.o_rd_last (rd_last),
		.o_busy    (o_busy),
		.o_done    (o_done)
	);

	////////////////////////////////////////
	// Delta and weight stores
	////////////////////////////////////////

	bp_sram #(.DEPTH(D_DEPTH)) d_mem0 (
		.clk     (clk),
		.i_we    (i_d_we),
		.i_waddr (i_d_waddr),
		.i_raddr (addr_d),
		.i_wdata (i_d_wdata),
		.o_rdata (d_rdata)
	);

	bp_sram #(.DEPTH(W_DEPTH)) w_mem0 (
		.clk     (clk),
		.i_we    (i_w_we),
		.i_waddr (i_w_waddr),
		.i_raddr (addr_w),
		.i_wdata (i_w_wdata),
		.o_rdata (w_rdata)
	);

	// Multiply-accumulate
	dot_accum acc0 (
		.clk      (clk),
		.rst      (rst),
		.i_vld    (rd_vld),
		.i_last   (rd_last),
		.i_d      (d_rdata),
		.i_w      (w_rdata),
		.o_dx     (o_dx),
		.o_dx_vld (o_dx_vld)
	);

endmodule

/* tests/tb_bp_dxdout.sv */
`timescale 1ns/1ps

module tb_bp_dxdout;
	import lstm_shape_pkg::*;
	import lstm_fixed_pkg::*;

	// Quiet window of two dot-product slots after each run
	localparam int QUIET = 2 * (NUM_CELL + DELAY);
	// One full walk of all dot products plus margin
	localparam int RUN_CYC = NUM_DOTS * (NUM_CELL + DELAY) + 10;
	// Worst-case load length of one word per cycle plus margin
	localparam int LOAD_CYC = D_DEPTH + W_DEPTH + 4;
	// Full, reload, busy, two saturation and spacing runs
	localparam int NUM_RUNS = 6;
	localparam int CYCLE_LIMIT = NUM_RUNS * (RUN_CYC + LOAD_CYC + QUIET) + 10 + 20;

	logic  clk;
	logic  rst;
	logic  i_start;
	logic  i_d_we;
	addr_t i_d_waddr;
	dat_t  i_d_wdata;
	logic  i_w_we;
	addr_t i_w_waddr;
	dat_t  i_w_wdata;
	dat_t  o_dx;
	logic  o_dx_vld;
	logic  o_busy;
	logic  o_done;

	// Stimulus source state
	logic [31:0] lfsr = 32'hbfca;
	int cycle = 0;
	int start_cyc = 0;
	int done_cnt = 0;
	int pass_cnt;
	int fail_cnt;
	int test_errs;
	// Captured results and their cycle stamps
	dat_t got_q[$];
	int   got_cyc[$];
	dat_t exp_q[$];
	// Shadow copies of both stores
	dat_t d_img [D_DEPTH];
	dat_t w_img [W_DEPTH];

	bp_dxdout_top dut0 (
		.clk       (clk),
		.rst       (rst),
		.i_start   (i_start),
		.i_d_we    (i_d_we),
		.i_d_waddr (i_d_waddr),
		.i_d_wdata (i_d_wdata),
		.i_w_we    (i_w_we),
		.i_w_waddr (i_w_waddr),
		.i_w_wdata (i_w_wdata),
		.o_dx      (o_dx),
		.o_dx_vld  (o_dx_vld),
		.o_busy    (o_busy),
		.o_done    (o_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////
	// Cycle count, timeout, monitor
	////////////////////////////////////////

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT)
		begin
			$display("Simulation timed out after %0d cycles", cycle);
			$display("Regression failed");
			$finish;
		end
	end

	always @(posedge clk)
	begin
		if (!rst && o_dx_vld)
		begin
			got_q.push_back(o_dx);
			got_cyc.push_back(cycle);
		end
		if (!rst && o_done)
			done_cnt <= done_cnt + 1;
		// Start edge counts only when the sequencer accepts it
		if (!rst && i_start && !o_busy)
			start_cyc <= cycle;
	end

	// One bit per Galois step with taps x^32+x^22+x^2+x+1
	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int k = 0; k < n; k++)
		begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// Mode 0 random within +-2^10
	// Mode 1 all max
	// Mode 2 max deltas against min weights
	task automatic fill_images(input int mode);
		for (int i = 0; i < D_DEPTH; i++)
		begin
			if (mode == 0)
				d_img[i] = dat_t'(take_bits(11) - 1024);
			else
				d_img[i] = DAT_MAX;
		end
		for (int i = 0; i < W_DEPTH; i++)
		begin
			if (mode == 0)
				w_img[i] = dat_t'(take_bits(11) - 1024);
			else if (mode == 1)
				w_img[i] = DAT_MAX;
			else
				w_img[i] = DAT_MIN;
		end
	endtask

	task automatic load_images();
		for (int i = 0; i < D_DEPTH || i < W_DEPTH; i++)
		begin
			i_d_we = (i < D_DEPTH);
			i_w_we = (i < W_DEPTH);
			i_d_waddr = addr_t'(i);
			i_w_waddr = addr_t'(i);
			if (i < D_DEPTH)
				i_d_wdata = d_img[i];
			if (i < W_DEPTH)
				i_w_wdata = w_img[i];
			@(posedge clk);
			#1;
		end
		i_d_we = 1'b0;
		i_w_we = 1'b0;
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Timestep descending then input ascending
	// Floor shift then clamp
	function automatic void build_model();
		longint sum;
		longint sh;
		exp_q.delete();
		for (int t = TIMESTEP - 1; t >= 0; t--)
		begin
			for (int n = 0; n < NUM_INPUT; n++)
			begin
				sum = 0;
				for (int c = 0; c < NUM_CELL; c++)
					sum += longint'(d_img[t * NUM_CELL + c])
						* longint'(w_img[n + c * NUM_INPUT]);
				sh = sum >>> FRAC_BITS;
				if (sh > longint'(DAT_MAX))
					exp_q.push_back(DAT_MAX);
				else if (sh < longint'(DAT_MIN))
					exp_q.push_back(DAT_MIN);
				else
					exp_q.push_back(dat_t'(sh));
			end
		end
	endfunction

	task automatic check_dx(input string name, input dat_t exp, input dat_t act);
		if (exp !== act)
		begin
			$display("[FAIL] %s expected %0d actual %0d", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act)
		begin
			$display("[FAIL] %s expected %b actual %b", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("%s", msg);
		test_errs++;
	endtask

	// Latest run must give one fixed value for every result
	task automatic expect_constant_results(input string name, input dat_t exp);
		int first;
		first = got_q.size() - NUM_DOTS;
		if (first < 0)
		begin
			report_error($sformatf("%s: too few results captured", name));
		end
		else
		begin
			for (int k = 0; k < NUM_DOTS; k++)
				check_dx($sformatf("%s result %0d", name, k), exp, got_q[first + k]);
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errs == 0)
		begin
			$display("Test %s: ok", name);
			pass_cnt++;
		end
		else
		begin
			$display("Test %s: %0d errors", name, test_errs);
			fail_cnt++;
		end
		test_errs = 0;
	endtask

	// Start pulse plus optional second pulse while busy before collecting results
	task automatic exec_run(input string name, input bit poke_busy, input bit check_timing);
		int base;
		int done_base;
		int n;
		int gap;
		base = got_q.size();
		done_base = done_cnt;
		build_model();
		i_start = 1'b1;
		@(posedge clk);
		#1;
		i_start = 1'b0;
		if (poke_busy)
		begin
			repeat (NUM_CELL + DELAY) @(posedge clk);
			#1;
			i_start = 1'b1;
			@(posedge clk);
			#1;
			i_start = 1'b0;
		end
		while (got_q.size() - base < NUM_DOTS)
		begin
			@(posedge clk);
			#1;
		end
		// Extra results or done pulses would land in this window
		repeat (QUIET) @(posedge clk);
		#1;
		n = got_q.size() - base;
		if (n != NUM_DOTS)
			report_error($sformatf("%s: %0d results arrived, %0d expected",
				name, n, NUM_DOTS));
		if (done_cnt - done_base != 1)
			report_error($sformatf("%s: done pulsed %0d times, once expected",
				name, done_cnt - done_base));
		for (int k = 0; k < NUM_DOTS && k < n; k++)
			check_dx($sformatf("%s result %0d", name, k), exp_q[k], got_q[base + k]);
		if (check_timing && n > 0)
		begin
			gap = got_cyc[base] - start_cyc;
			if (gap != NUM_CELL + 3)
				report_error($sformatf("%s: first result %0d cycles after start, %0d expected",
					name, gap, NUM_CELL + 3));
			for (int k = 1; k < n; k++)
			begin
				gap = got_cyc[base + k] - got_cyc[base + k - 1];
				if (gap != NUM_CELL + DELAY)
					report_error($sformatf("%s: result %0d came %0d cycles after the previous",
						name, k, gap));
			end
		end
		check_flag({name, " busy after run"}, 1'b0, o_busy);
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		rst = 1'b1;
		i_start = 1'b0;
		i_d_we = 1'b0;
		i_d_waddr = '0;
		i_d_wdata = '0;
		i_w_we = 1'b0;
		i_w_waddr = '0;
		i_w_wdata = '0;
		pass_cnt = 0;
		fail_cnt = 0;
		test_errs = 0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		@(posedge clk);
		#1;

		check_flag("reset busy", 1'b0, o_busy);
		check_flag("reset done", 1'b0, o_done);
		check_flag("reset dx_vld", 1'b0, o_dx_vld);
		finish_test("reset_state");

		fill_images(0);
		load_images();
		exec_run("full_run", 1'b0, 1'b0);
		finish_test("full_run");

		// Fresh contents so nothing may carry over
		fill_images(0);
		load_images();
		exec_run("reload_rerun", 1'b0, 1'b0);
		finish_test("reload_rerun");

		fill_images(0);
		load_images();
		exec_run("start_while_busy", 1'b1, 1'b0);
		finish_test("start_while_busy");

		fill_images(1);
		load_images();
		exec_run("saturation_max", 1'b0, 1'b0);
		expect_constant_results("saturation_max clamp", DAT_MAX);
		fill_images(2);
		load_images();
		exec_run("saturation_min", 1'b0, 1'b0);
		expect_constant_results("saturation_min clamp", DAT_MIN);
		finish_test("saturation");

		fill_images(0);
		load_images();
		exec_run("result_spacing", 1'b0, 1'b1);
		finish_test("result_spacing");

		$display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* flist.f */
source/lstm_shape_pkg.sv
source/lstm_fixed_pkg.sv
source/bp_sram.sv
source/addr_gen_bp_dxdout.sv
source/dot_accum.sv
source/bp_dxdout_top.sv
tests/tb_bp_dxdout.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the log holds the pass message
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_bp_dxdout \
	&& ./obj_dir/Vtb_bp_dxdout | tee sim.log \
	|| { echo "Build or simulation error"; exit 1; }
grep -q "Regression passed" sim.log && exit 0 || exit 1
